//--- hw/periph_pkg.sv
`default_nettype none

package periph_pkg;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    localparam logic [15:0] addr_div  = 16'hFF04;
    localparam logic [15:0] addr_tima = 16'hFF05;
    localparam logic [15:0] addr_tma  = 16'hFF06;
    localparam logic [15:0] addr_tac  = 16'hFF07;
    localparam logic [15:0] addr_if   = 16'hFF0F;
    localparam logic [15:0] addr_ie   = 16'hFFFF;

    localparam logic [7:0] unmapped_read = 8'hFF;

    // Register offsets inside the timer block
    localparam logic [1:0] sel_div  = 2'd0;
    localparam logic [1:0] sel_tima = 2'd1;
    localparam logic [1:0] sel_tma  = 2'd2;
    localparam logic [1:0] sel_tac  = 2'd3;

    // Register offsets inside the interrupt block
    localparam logic [1:0] sel_if = 2'd0;
    localparam logic [1:0] sel_ie = 2'd1;

    ////////////////////////////////////////////////////////////
    // Interrupts
    ////////////////////////////////////////////////////////////

    localparam int irq_count = 5;
    localparam logic [7:0] irq_vector_base = 8'h40;
    localparam int irq_vector_step = 8;
    // Bit 0 vblank, 1 lcd status, 2 timer, 3 serial, 4 joypad
    localparam int irq_timer = 2;

    typedef logic [7:0] irq_vec_t;

    ////////////////////////////////////////////////////////////
    // Bus and register access
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        write;
    } bus_req_t;

    typedef enum logic [1:0] {
        target_none  = 2'd0,
        target_timer = 2'd1,
        target_intr  = 2'd2
    } reg_target_e;

    typedef struct packed {
        reg_target_e target;
        logic [1:0]  reg_sel;
        logic [7:0]  wdata;
        logic        write;
        logic        strobe;
    } reg_access_t;

    // TAC as written by software, and its two live fields
    typedef struct packed {
        logic [4:0] reserved;
        logic       enable;
        logic [1:0] clock_sel;
    } tac_fields_t;

    typedef union packed {
        logic [7:0]  raw;
        tac_fields_t f;
    } tac_u;

endpackage

`default_nettype wire

//--- hw/bus_request_port.sv
`timescale 1ns/1ps
`default_nettype none

module bus_request_port (
    input  wire                     clk,
    input  wire                     rst,
    input  wire periph_pkg::bus_req_t req,
    input  wire                     req_valid,
    input  wire                     rsp_full,
    output logic                    req_ready,
    output periph_pkg::reg_access_t access,
    output logic                    read_strobe
);
    import periph_pkg::*;

    bus_req_t req_q;
    logic     held_q;
    logic     accept;
    logic     fire;

    // A read stays put while the response slot is taken
    assign fire = held_q && (req_q.write || !rsp_full);

    assign req_ready   = !held_q || fire;
    assign accept      = req_valid && req_ready;
    assign read_strobe = fire && !req_q.write;

    ////////////////////////////////////////////////////////////
    // Holding register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_q <= 1'b0;
        end else if (accept) begin
            held_q <= 1'b1;
        end else if (fire) begin
            held_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        access.wdata   = req_q.wdata;
        access.write   = req_q.write;
        access.strobe  = fire;
        access.target  = target_none;
        access.reg_sel = 2'd0;
        case (req_q.addr)
            addr_div: begin
                access.target  = target_timer;
                access.reg_sel = sel_div;
            end
            addr_tima: begin
                access.target  = target_timer;
                access.reg_sel = sel_tima;
            end
            addr_tma: begin
                access.target  = target_timer;
                access.reg_sel = sel_tma;
            end
            addr_tac: begin
                access.target  = target_timer;
                access.reg_sel = sel_tac;
            end
            addr_if: begin
                access.target  = target_intr;
                access.reg_sel = sel_if;
            end
            addr_ie: begin
                access.target  = target_intr;
                access.reg_sel = sel_ie;
            end
            default: begin
                // Unmapped reads return the fill value
                access.target = target_none;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/tima_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tima_timer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire periph_pkg::reg_access_t access,
    output logic [7:0]                 rdata,
    output logic                       overflow
);
    import periph_pkg::*;

    logic [15:0] div_q;
    logic [7:0]  tima_q;
    logic [7:0]  tma_q;
    tac_u        tac_q;

    logic        wr_timer;
    logic        div_bit;
    logic        tick_src;
    logic        tick_src_q;
    logic        tick;
    logic [8:0]  tima_inc;
    logic        reload_q;
    logic        overflow_q;

    assign wr_timer = access.strobe && access.write && (access.target == target_timer);

    ////////////////////////////////////////////////////////////
    // Clock select and edge detect
    ////////////////////////////////////////////////////////////

    // Periods 1024, 16, 64, 256 clocks
    always_comb begin
        case (tac_q.f.clock_sel)
            2'd0:    div_bit = div_q[9];
            2'd1:    div_bit = div_q[3];
            2'd2:    div_bit = div_q[5];
            default: div_bit = div_q[7];
        endcase
    end

    assign tick_src = div_bit && tac_q.f.enable;

    // Falling edge of the gated bit; a DIV clear can also cause one
    assign tick     = tick_src_q && !tick_src;
    assign tima_inc = {1'b0, tima_q} + 9'd1;

    ////////////////////////////////////////////////////////////
    // Divider
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_q <= 16'd0;
        end else if (wr_timer && (access.reg_sel == sel_div)) begin
            div_q <= 16'd0;
        end else begin
            div_q <= div_q + 16'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // TIMA, TMA, TAC
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tima_q     <= 8'd0;
            tma_q      <= 8'd0;
            tac_q      <= '0;
            tick_src_q <= 1'b0;
            reload_q   <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            tick_src_q <= tick_src;
            overflow_q <= 1'b0;

            // Reload wins, and a TIMA write in that cycle is lost
            if (reload_q) begin
                tima_q     <= tma_q;
                reload_q   <= 1'b0;
                overflow_q <= 1'b1;
            end else if (wr_timer && (access.reg_sel == sel_tima)) begin
                tima_q <= access.wdata;
            end else if (tick) begin
                tima_q   <= tima_inc[7:0];
                reload_q <= tima_inc[8];
            end

            if (wr_timer && (access.reg_sel == sel_tma)) begin
                tma_q <= access.wdata;
            end
            if (wr_timer && (access.reg_sel == sel_tac)) begin
                tac_q.raw <= access.wdata;
            end
        end
    end

    assign overflow = overflow_q;

    // Read mux
    always_comb begin
        rdata = tima_q;
        case (access.reg_sel)
            sel_div:  rdata = div_q[15:8];
            sel_tima: rdata = tima_q;
            sel_tma:  rdata = tma_q;
            sel_tac:  rdata = tac_q.raw;
            default:  rdata = tima_q;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/interrupt_flags.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_flags (
    input  wire                        clk,
    input  wire                        rst,
    input  wire periph_pkg::reg_access_t access,
    input  wire                        timer_overflow,
    input  wire [3:0]                  ext_irq,
    input  wire                        irq_ack,
    output logic [7:0]                 rdata,
    output logic                       irq_req,
    output periph_pkg::irq_vec_t       irq_vector
);
    import periph_pkg::*;

    logic [irq_count-1:0] if_q;
    logic [irq_count-1:0] ie_q;
    logic [irq_count-1:0] src;
    logic [irq_count-1:0] pending;
    logic [irq_count-1:0] ack_mask;
    logic [irq_count-1:0] if_next;
    logic [2:0]           sel_idx;
    logic                 wr_intr;

    assign wr_intr = access.strobe && access.write && (access.target == target_intr);

    // External lines fill the slots around the timer bit
    always_comb begin
        src[1:0]       = ext_irq[1:0];
        src[irq_timer] = timer_overflow;
        src[4:3]       = ext_irq[3:2];
    end

    ////////////////////////////////////////////////////////////
    // Priority with the lowest bit first
    ////////////////////////////////////////////////////////////

    assign pending = if_q & ie_q;

    always_comb begin
        sel_idx = 3'd0;
        for (int i = irq_count - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_idx = 3'(i);
            end
        end
    end

    assign irq_req    = |pending;
    assign irq_vector = irq_vector_base + irq_vec_t'(sel_idx) * irq_vec_t'(irq_vector_step);

    ////////////////////////////////////////////////////////////
    // IF and IE
    ////////////////////////////////////////////////////////////

    always_comb begin
        ack_mask = '0;
        if (irq_ack && irq_req) begin
            ack_mask[sel_idx] = 1'b1;
        end
        if_next = if_q;
        if (wr_intr && (access.reg_sel == sel_if)) begin
            if_next = access.wdata[irq_count-1:0];
        end
        // New pulses beat the acknowledge clear
        if_next = (if_next & ~ack_mask) | src;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_q <= '0;
            ie_q <= '0;
        end else begin
            if_q <= if_next;
            if (wr_intr && (access.reg_sel == sel_ie)) begin
                ie_q <= access.wdata[irq_count-1:0];
            end
        end
    end

    // Unused upper bits read high
    always_comb begin
        case (access.reg_sel)
            sel_if:  rdata = {{(8 - irq_count){1'b1}}, if_q};
            sel_ie:  rdata = {{(8 - irq_count){1'b1}}, ie_q};
            default: rdata = unmapped_read;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/read_response_port.sv
`timescale 1ns/1ps
`default_nettype none

module read_response_port (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        read_strobe,
    input  wire [7:0]                  timer_rdata,
    input  wire [7:0]                  intr_rdata,
    input  wire periph_pkg::reg_target_e target,
    input  wire                        rsp_ready,
    output logic [7:0]                 rsp_data,
    output logic                       rsp_valid,
    output logic                       full
);
    import periph_pkg::*;

    logic [7:0] read_sel;
    logic [7:0] data_q;
    logic       valid_q;

    always_comb begin
        case (target)
            target_timer: read_sel = timer_rdata;
            target_intr:  read_sel = intr_rdata;
            default:      read_sel = unmapped_read;
        endcase
    end

    // Slot frees up in the same cycle it drains
    assign full = valid_q && !rsp_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (read_strobe) begin
            valid_q <= 1'b1;
        end else if (rsp_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (read_strobe) begin
            data_q <= read_sel;
        end
    end

    assign rsp_data  = data_q;
    assign rsp_valid = valid_q;

endmodule

`default_nettype wire

//--- hw/periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire periph_pkg::bus_req_t req,
    input  wire                      req_valid,
    input  wire                      rsp_ready,
    input  wire [3:0]                ext_irq,
    input  wire                      irq_ack,
    output logic                     req_ready,
    output logic [7:0]               rsp_data,
    output logic                     rsp_valid,
    output logic                     irq_req,
    output periph_pkg::irq_vec_t     irq_vector
);
    import periph_pkg::*;

    reg_access_t access;
    logic        read_strobe;
    logic        rsp_full;
    logic [7:0]  timer_rdata;
    logic [7:0]  intr_rdata;
    logic        timer_overflow;

    ////////////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////////////

    bus_request_port bus_request_port_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_valid   (req_valid),
        .rsp_full    (rsp_full),
        .req_ready   (req_ready),
        .access      (access),
        .read_strobe (read_strobe)
    );

    read_response_port read_response_port_inst (
        .clk         (clk),
        .rst         (rst),
        .read_strobe (read_strobe),
        .timer_rdata (timer_rdata),
        .intr_rdata  (intr_rdata),
        .target      (access.target),
        .rsp_ready   (rsp_ready),
        .rsp_data    (rsp_data),
        .rsp_valid   (rsp_valid),
        .full        (rsp_full)
    );

    ////////////////////////////////////////////////////////////
    // Timer and interrupt controller
    ////////////////////////////////////////////////////////////

    tima_timer tima_timer_inst (
        .clk      (clk),
        .rst      (rst),
        .access   (access),
        .rdata    (timer_rdata),
        .overflow (timer_overflow)
    );

    interrupt_flags interrupt_flags_inst (
        .clk            (clk),
        .rst            (rst),
        .access         (access),
        .timer_overflow (timer_overflow),
        .ext_irq        (ext_irq),
        .irq_ack        (irq_ack),
        .rdata          (intr_rdata),
        .irq_req        (irq_req),
        .irq_vector     (irq_vector)
    );

endmodule

`default_nettype wire

//--- testbench/periph_properties.sv
`timescale 1ns/1ps
`default_nettype none

module periph_properties (
    input wire                       clk,
    input wire                       rst,
    input wire periph_pkg::bus_req_t req,
    input wire                       req_valid,
    input wire                       req_ready,
    input wire [7:0]                 rsp_data,
    input wire                       rsp_valid,
    input wire                       rsp_ready,
    input wire                       irq_req,
    input wire periph_pkg::irq_vec_t irq_vector
);

    ////////////////////////////////////////////////////////////
    // Stream handshakes
    ////////////////////////////////////////////////////////////

    // Request held steady until taken
    req_stable: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("request changed while req_ready was low");

    // Response held steady until taken
    rsp_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
        else $error("response changed while rsp_ready was low");

    rsp_idle_after_reset: assert property (@(posedge clk) rst |=> !rsp_valid)
        else $error("rsp_valid high right after reset");

    ////////////////////////////////////////////////////////////
    // Interrupt line
    ////////////////////////////////////////////////////////////

    irq_vector_range: assert property (@(posedge clk) disable iff (rst)
        irq_req |-> irq_vector >= 8'h40 && irq_vector <= 8'h60)
        else $error("irq_vector 0x%02h outside the vector table", irq_vector);

endmodule

bind periph_top periph_properties periph_properties_inst (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .rsp_data   (rsp_data),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .irq_req    (irq_req),
    .irq_vector (irq_vector)
);

`default_nettype wire

//--- testbench/periph_tb.sv
`timescale 1ns/1ps
`default_nettype none

module periph_tb;
    import periph_pkg::*;

    localparam int flush_limit     = 5000;
    localparam int irq_limit       = 200;
    localparam int watchdog_cycles = 200000;

    logic       clk;
    logic       rst;
    bus_req_t   req;
    logic       req_valid;
    logic       req_ready;
    logic       rsp_ready;
    logic [7:0] rsp_data;
    logic       rsp_valid;
    logic [3:0] ext_irq;
    logic       irq_ack;
    logic       irq_req;
    irq_vec_t   irq_vector;

    // Stimulus queues and bookkeeping
    logic [31:0] rng_state;
    bus_req_t    req_list[$];
    bit          req_check[$];
    logic [7:0]  exp_data[$];
    bit          exp_checked[$];
    bit          toggle_ready;
    logic [3:0]  pulse_ext;
    logic        pulse_ack;
    logic [7:0]  last_rdata;
    int          cycle_count;
    int          accept_cycle;
    int          rsp_cycle;
    int          errors;
    int          checks;
    int          test_errors;

    // Expected register file
    logic [7:0] model_tma;
    logic [7:0] model_tac;
    logic [4:0] model_ie;
    logic [4:0] model_if;

    periph_top periph_top_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .rsp_ready  (rsp_ready),
        .ext_irq    (ext_irq),
        .irq_ack    (irq_ack),
        .req_ready  (req_ready),
        .rsp_data   (rsp_data),
        .rsp_valid  (rsp_valid),
        .irq_req    (irq_req),
        .irq_vector (irq_vector)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [15:0] pick_reg(input logic [1:0] idx);
        case (idx)
            2'd0:    return addr_tma;
            2'd1:    return addr_tac;
            2'd2:    return addr_ie;
            default: return addr_if;
        endcase
    endfunction

    function automatic bit is_mapped(input logic [15:0] addr);
        return (addr == addr_div) || (addr == addr_tima) || (addr == addr_tma) ||
               (addr == addr_tac) || (addr == addr_if) || (addr == addr_ie);
    endfunction

    // Upper three bits of IF and IE read as ones and unmapped addresses as 0xFF
    function automatic logic [7:0] model_read(input logic [15:0] addr);
        case (addr)
            addr_tma: return model_tma;
            addr_tac: return model_tac;
            addr_ie:  return {3'b111, model_ie};
            addr_if:  return {3'b111, model_if};
            default:  return 8'hFF;
        endcase
    endfunction

    task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
        case (addr)
            addr_tma: model_tma = data;
            addr_tac: model_tac = data;
            addr_ie:  model_ie = data[4:0];
            addr_if:  model_if = data[4:0];
            default:  ;
        endcase
    endtask

    // Lowest pending bit wins with 8 bytes per vector
    function automatic logic [7:0] expected_vector(input logic [4:0] pend);
        logic [7:0] vec;
        vec = 8'h40;
        for (int i = 4; i >= 0; i--) begin
            if (pend[i]) begin
                vec = 8'h40 + 8'(8 * i);
            end
        end
        return vec;
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus driver
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] got);
        $display("[FAIL] %s: expected 0x%02h, got 0x%02h", name, expected, got);
        errors++;
    endtask

    // Drive one clock on the falling edge, then note what the next rising edge takes
    task automatic step();
        bus_req_t    cur;
        bit          chk;
        logic [7:0]  expected;
        logic [31:0] rnd;
        @(negedge clk);
        cycle_count++;
        if (toggle_ready) begin
            rnd = next_random();
            rsp_ready = rnd[3];
        end else begin
            rsp_ready = 1'b1;
        end
        ext_irq = pulse_ext;
        irq_ack = pulse_ack;
        pulse_ext = 4'd0;
        pulse_ack = 1'b0;
        if (req_list.size() > 0) begin
            req = req_list[0];
            req_valid = 1'b1;
        end else begin
            req_valid = 1'b0;
        end
        #1;
        if (rsp_valid && rsp_ready) begin
            last_rdata = rsp_data;
            rsp_cycle = cycle_count;
            if (exp_data.size() == 0) begin
                $display("a response arrived with no read outstanding");
                errors++;
            end else begin
                expected = exp_data.pop_front();
                chk = exp_checked.pop_front();
                if (chk) begin
                    checks++;
                    if (rsp_data !== expected) begin
                        report_mismatch("rsp_data", expected, rsp_data);
                    end
                end
            end
        end
        if (req_valid && req_ready) begin
            cur = req_list.pop_front();
            chk = req_check.pop_front();
            accept_cycle = cycle_count;
            if (cur.write) begin
                model_write(cur.addr, cur.wdata);
            end else begin
                exp_data.push_back(model_read(cur.addr));
                exp_checked.push_back(chk);
            end
        end
    endtask

    task automatic queue_write(input logic [15:0] addr, input logic [7:0] data);
        req_list.push_back({addr, data, 1'b1});
        req_check.push_back(1'b0);
    endtask

    task automatic queue_read(input logic [15:0] addr, input bit checked);
        req_list.push_back({addr, 8'h00, 1'b0});
        req_check.push_back(checked);
    endtask

    task automatic flush();
        int n;
        n = 0;
        while ((req_list.size() > 0 || exp_data.size() > 0) && n < flush_limit) begin
            step();
            n++;
        end
        if (req_list.size() > 0 || exp_data.size() > 0) begin
            $display("bus transfers did not finish within %0d cycles", flush_limit);
            errors++;
            req_list.delete();
            req_check.delete();
            exp_data.delete();
            exp_checked.delete();
        end
    endtask

    task automatic read_value(input logic [15:0] addr, output logic [7:0] data);
        queue_read(addr, 1'b0);
        flush();
        data = last_rdata;
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        do begin
            step();
            n++;
        end while (irq_req !== level && n < irq_limit);
        checks++;
        if (irq_req !== level) begin
            $display("irq_req did not reach %0b within %0d cycles", level, irq_limit);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    initial begin
        int          k;
        int          n;
        int          gap;
        int          elapsed;
        int          clear_cycle;
        logic [31:0] rnd;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  val;
        logic [7:0]  prev;
        logic [7:0]  exp_vec;
        logic [3:0]  ext_bits;
        logic [4:0]  if_bits;
        logic [4:0]  ie_bits;
        logic [4:0]  pend;

        rng_state = 32'd70708;
        rst = 1'b1;
        req = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        ext_irq = 4'd0;
        irq_ack = 1'b0;
        toggle_ready = 1'b0;
        pulse_ext = 4'd0;
        pulse_ack = 1'b0;
        last_rdata = 8'd0;
        cycle_count = 0;
        accept_cycle = 0;
        rsp_cycle = 0;
        errors = 0;
        checks = 0;
        model_tma = 8'd0;
        model_tac = 8'd0;
        model_ie = 5'd0;
        model_if = 5'd0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Writes and reads with a stalling response side
        test_errors = errors;
        toggle_ready = 1'b1;
        for (k = 0; k < 40; k++) begin
            rnd = next_random();
            addr = pick_reg(rnd[1:0]);
            data = rnd[15:8];
            // Keep the timer stopped
            if (addr == addr_tac) begin
                data = data & 8'hFB;
            end
            queue_write(addr, data);
            rnd = next_random();
            queue_read(pick_reg(rnd[1:0]), 1'b1);
        end
        flush();
        queue_write(addr_ie, 8'h00);
        queue_write(addr_if, 8'h00);
        queue_write(addr_tac, 8'h00);
        flush();
        end_test("1 register readback");

        test_errors = errors;
        for (k = 0; k < 20; k++) begin
            rnd = next_random();
            addr = rnd[15:0];
            if (is_mapped(addr)) begin
                addr = addr ^ 16'h0100;
            end
            queue_read(addr, 1'b1);
        end
        flush();
        toggle_ready = 1'b0;
        end_test("2 unmapped reads");

        // DIV counts 256 clocks per step since the clear
        test_errors = errors;
        rnd = next_random();
        queue_write(addr_div, rnd[7:0]);
        flush();
        clear_cycle = accept_cycle;
        prev = 8'd0;
        for (k = 0; k < 14; k++) begin
            rnd = next_random();
            if (k == 0) begin
                gap = 300 + int'(rnd % 32'd2000);
            end else begin
                gap = 3000 + int'(rnd % 32'd800);
            end
            repeat (gap) step();
            read_value(addr_div, val);
            elapsed = rsp_cycle - clear_cycle;
            checks++;
            if (int'(val) > elapsed / 256 || int'(val) < (elapsed - 4) / 256) begin
                $display("[FAIL] div: expected 0x%02h to 0x%02h, got 0x%02h",
                         (elapsed - 4) / 256, elapsed / 256, val);
                errors++;
            end
            checks++;
            if (val < prev) begin
                $display("[FAIL] div: expected at least 0x%02h, got 0x%02h", prev, val);
                errors++;
            end
            prev = val;
        end
        end_test("3 divider");

        test_errors = errors;
        rnd = next_random();
        queue_write(addr_if, 8'h00);
        queue_write(addr_ie, 8'h04);
        queue_write(addr_tma, rnd[7:0]);
        queue_write(addr_tima, 8'hFE);
        queue_write(addr_tac, 8'h05);
        flush();
        wait_irq(1'b1);
        checks++;
        if (irq_vector !== 8'h50) begin
            report_mismatch("irq_vector", 8'h50, irq_vector);
        end
        read_value(addr_tima, val);
        checks++;
        if (val !== model_tma && val !== model_tma + 8'd1) begin
            $display("[FAIL] tima: expected 0x%02h or 0x%02h, got 0x%02h",
                     model_tma, model_tma + 8'd1, val);
            errors++;
        end
        read_value(addr_if, val);
        checks++;
        if (val[2] !== 1'b1) begin
            $display("[FAIL] if: expected bit 2 set, got 0x%02h", val);
            errors++;
        end
        // Stop the timer and let a late overflow settle before clearing IF
        queue_write(addr_tac, 8'h00);
        flush();
        repeat (8) step();
        queue_write(addr_if, 8'h00);
        queue_write(addr_ie, 8'h00);
        flush();
        end_test("4 timer overflow");

        test_errors = errors;
        for (k = 0; k < 4; k++) begin
            queue_write(addr_ie, 8'h00);
            queue_write(addr_if, 8'h00);
            flush();
            rnd = next_random();
            ext_bits = rnd[3:0];
            if (ext_bits == 4'd0) begin
                ext_bits = 4'b0100;
            end
            pulse_ext = ext_bits;
            // External lines sit around the timer bit
            model_if = model_if | {ext_bits[3:2], 1'b0, ext_bits[1:0]};
            for (n = 0; n < 4; n++) begin
                step();
                checks++;
                if (irq_req !== 1'b0) begin
                    $display("irq_req rose while every source was masked");
                    errors++;
                end
            end
            queue_read(addr_if, 1'b1);
            flush();
            queue_write(addr_ie, 8'h1F);
            flush();
            wait_irq(1'b1);
            exp_vec = expected_vector(model_if & model_ie);
            checks++;
            if (irq_vector !== exp_vec) begin
                report_mismatch("irq_vector", exp_vec, irq_vector);
            end
        end
        end_test("5 masking and priority");

        test_errors = errors;
        for (k = 0; k < 3; k++) begin
            rnd = next_random();
            if_bits = rnd[4:0];
            if (if_bits == 5'd0) begin
                if_bits = 5'b10000;
            end
            ie_bits = rnd[12:8] | (if_bits & (~if_bits + 5'd1));
            // Mask first so the old IE never meets the new IF
            queue_write(addr_ie, 8'h00);
            queue_write(addr_if, {3'b000, if_bits});
            queue_write(addr_ie, {3'b000, ie_bits});
            flush();
            n = 0;
            while ((model_if & model_ie) != 5'd0 && n < 6) begin
                wait_irq(1'b1);
                exp_vec = expected_vector(model_if & model_ie);
                checks++;
                if (irq_vector !== exp_vec) begin
                    report_mismatch("irq_vector", exp_vec, irq_vector);
                end
                pulse_ack = 1'b1;
                step();
                pend = model_if & model_ie;
                model_if = model_if & ~(pend & (~pend + 5'd1));
                n++;
            end
            step();
            checks++;
            if (irq_req !== 1'b0) begin
                $display("irq_req stayed high after every pending bit was acknowledged");
                errors++;
            end
            queue_read(addr_if, 1'b1);
            flush();
        end
        queue_write(addr_ie, 8'h00);
        queue_write(addr_if, 8'h00);
        flush();
        end_test("6 acknowledge");

        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Last resort against a stuck run
    initial begin
        int n;
        for (n = 0; n < watchdog_cycles; n++) begin
            @(posedge clk);
        end
        $display("simulation ran past %0d cycles", watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/periph_pkg.sv
hw/bus_request_port.sv
hw/tima_timer.sv
hw/interrupt_flags.sv
hw/read_response_port.sv
hw/periph_top.sv
testbench/periph_properties.sv
testbench/periph_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module periph_tb -f vlog.f -o periph_sim \
    && ./obj_dir/periph_sim | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
